/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module tb_vcache -f vlog.f -o tb_vcache

run: compile
	./obj_dir/tb_vcache | tee /dev/stderr | grep "test passed" > /dev/null

clean:
	rm -rf obj_dir

/* tb_dma_mem.sv */
module tb_dma_mem
  import vcache_pkg::*;
#(
  parameter int block_size_in_words_p = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    dma_pkt_v_i,
  input  vcache_dma_pkt_s         dma_pkt_i,
  output logic                    dma_pkt_ready_o,
  output logic                    dma_data_v_o,
  output logic [data_width_c-1:0] dma_data_o,
  input  logic                    dma_data_ready_i,
  input  logic                    dma_data_v_i,
  input  logic [data_width_c-1:0] dma_data_i,
  output logic                    dma_data_ready_o,
  output int                      err_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [data_width_c-1:0]     mem [logic [net_addr_width_c-1:0]];
  logic                        busy;
  logic                        is_write;
  logic                        fill_taken;
  logic [net_addr_width_c-1:0] base_addr;
  int                          beat;
  vcache_dma_pkt_s             aligned;

  function automatic logic [data_width_c-1:0] read_word(
    input logic [net_addr_width_c-1:0] a
  );
    if (mem.exists(a)) return mem[a];
    return {16'h0, a} * 32'd3 + 32'd7; // untouched words follow their address.
  endfunction

  task automatic check_dma(input string name, input vcache_dma_pkt_s exp,
                           input vcache_dma_pkt_s act);
    if (act !== exp) begin
      err_cnt_o++;
      $display("[FAIL] %s expected w=%0b addr=%h actual w=%0b addr=%h", name,
               exp.write_not_read, exp.addr, act.write_not_read, act.addr);
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      busy       = 1'b0;
      is_write   = 1'b0;
      fill_taken = 1'b0;
      beat       = 0;
      err_cnt_o  = 0;
    end else begin
      fill_taken = 1'b0;
      if (dma_data_v_i && !(busy && is_write)) begin
        err_cnt_o++;
        $display("write data was offered outside a write burst, the burst is too long");
      end else if (dma_data_v_i && dma_data_ready_o) begin
        mem[base_addr + 16'(beat)] = dma_data_i;
        beat++;
      end
      if (dma_data_v_o && dma_data_ready_i) begin
        beat++;
        fill_taken = 1'b1;
      end
      if (busy && beat == block_size_in_words_p) busy = 1'b0;
      if (dma_pkt_v_i && dma_pkt_ready_o) begin
        if (busy) begin
          err_cnt_o++;
          $display("a DMA command arrived before the previous burst was complete");
        end
        aligned      = dma_pkt_i;
        aligned.addr = dma_pkt_i.addr & ~16'(block_size_in_words_p - 1);
        check_dma("dma_align", aligned, dma_pkt_i);
        busy      = 1'b1;
        is_write  = dma_pkt_i.write_not_read;
        base_addr = dma_pkt_i.addr;
        beat      = 0;
      end
    end
  end

  initial begin
    dma_pkt_ready_o  = 1'b0;
    dma_data_v_o     = 1'b0;
    dma_data_o       = '0;
    dma_data_ready_o = 1'b0;
    forever begin
      @(negedge clk_i);
      dma_pkt_ready_o  = !rst_i && ($urandom_range(3) != 0);
      dma_data_ready_o = !rst_i && busy && is_write && ($urandom_range(3) != 0);
      if (!rst_i && busy && !is_write) begin
        if (!dma_data_v_o || fill_taken) dma_data_v_o = ($urandom_range(3) != 0);
        dma_data_o = read_word(base_addr + 16'(beat));
      end else begin
        dma_data_v_o = 1'b0;
      end
    end
  end

endmodule

/* tb_vcache.sv */
module tb_vcache
  import vcache_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_rand_c  = 500;
  localparam int total_req_c = num_rand_c + 11; // the directed requests come first.
  localparam int period_c    = 4;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    req_v;
  vcache_req_pkt_s         req;
  logic                    req_ready;
  logic                    resp_v;
  vcache_resp_pkt_s        resp;
  logic                    resp_ready;
  logic                    dma_pkt_v;
  vcache_dma_pkt_s         dma_pkt;
  logic                    dma_pkt_ready;
  logic                    fill_v;
  logic [data_width_c-1:0] fill_data;
  logic                    fill_ready;
  logic                    evict_v;
  logic [data_width_c-1:0] evict_data;
  logic                    evict_ready;

  logic [data_width_c-1:0] ref_mem [2**net_addr_width_c];
  vcache_resp_pkt_s        exp_q [$];
  string                   name_q [$];
  string                   cur_name;
  vcache_resp_pkt_s        exp_pkt;
  int req_cnt;
  int resp_cnt;
  int resp_err_cnt;
  int misc_err_cnt;
  int dma_err_cnt;

  always #(period_c / 2) clk = ~clk;

  vcache_top #(
    .sets_p                (4),
    .block_size_in_words_p (4)
  ) vcache_top_inst (
    .clk_i (clk), .rst_i (rst),
    .req_v_i (req_v), .req_i (req), .req_ready_o (req_ready),
    .resp_v_o (resp_v), .resp_o (resp), .resp_ready_i (resp_ready),
    .dma_pkt_v_o (dma_pkt_v), .dma_pkt_o (dma_pkt), .dma_pkt_ready_i (dma_pkt_ready),
    .dma_data_v_i (fill_v), .dma_data_i (fill_data), .dma_data_ready_o (fill_ready),
    .dma_data_v_o (evict_v), .dma_data_o (evict_data), .dma_data_ready_i (evict_ready)
  );

  tb_dma_mem #(
    .block_size_in_words_p (4)
  ) dma_mem_inst (
    .clk_i (clk), .rst_i (rst),
    .dma_pkt_v_i (dma_pkt_v), .dma_pkt_i (dma_pkt), .dma_pkt_ready_o (dma_pkt_ready),
    .dma_data_v_o (fill_v), .dma_data_o (fill_data), .dma_data_ready_i (fill_ready),
    .dma_data_v_i (evict_v), .dma_data_i (evict_data), .dma_data_ready_o (evict_ready),
    .err_cnt_o (dma_err_cnt)
  );

  task automatic check_resp(input string name, input vcache_resp_pkt_s exp,
                            input vcache_resp_pkt_s act);
    if (act !== exp) begin
      resp_err_cnt++;
      $display("[FAIL] %s expected op=%0d x=%0d y=%0d id=%0d data=%h", name,
               exp.op, exp.dst_x, exp.dst_y, exp.load_id, exp.data);
      $display("[FAIL] %s actual op=%0d x=%0d y=%0d id=%0d data=%h", name,
               act.op, act.dst_x, act.dst_y, act.load_id, act.data);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      misc_err_cnt++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic send_req(input string name, input vcache_op_e op,
                          input logic [net_addr_width_c-1:0] addr,
                          input logic [data_width_c-1:0] data);
    logic taken;
    cur_name    = name;
    req.op      = op;
    req.addr    = addr;
    req.data    = data;
    req.src_x   = 4'($urandom_range(15));
    req.src_y   = 3'($urandom_range(7));
    req.load_id = 5'($urandom_range(31));
    req_v       = 1'b1;
    taken       = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = req_ready;
      @(negedge clk);
    end
    req_v = 1'b0;
  endtask

  // the flat model sees requests in the order the cache serves them.
  always @(posedge clk) begin
    if (!rst && req_v && req_ready) begin
      exp_pkt.op      = req.op;
      exp_pkt.dst_x   = req.src_x;
      exp_pkt.dst_y   = req.src_y;
      exp_pkt.load_id = req.load_id;
      exp_pkt.data    = (req.op == e_vcache_st) ? '0 : ref_mem[req.addr];
      if (req.op == e_vcache_st) ref_mem[req.addr] = req.data;
      exp_q.push_back(exp_pkt);
      name_q.push_back(cur_name);
      req_cnt++;
    end
    if (!rst && resp_v && resp_ready) begin
      if (exp_q.size() == 0) begin
        resp_err_cnt++;
        $display("a response came out while no request was outstanding");
      end else begin
        check_resp(name_q.pop_front(), exp_q.pop_front(), resp);
      end
      resp_cnt++;
    end
  end

  initial begin
    resp_ready = 1'b0;
    forever begin
      @(negedge clk);
      resp_ready = !rst && ($urandom_range(3) != 0);
    end
  end

  initial begin
    #((total_req_c * 40 + 10) * period_c);
    $display("timeout: the run did not drain after %0d requests", total_req_c);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(68156));
    rst      = 1'b1;
    req_v    = 1'b0;
    req      = '0;
    cur_name = "reset";
    for (int a = 0; a < 2**net_addr_width_c; a++) begin
      ref_mem[16'(a)] = 32'(a) * 32'd3 + 32'd7;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    if (resp_v || dma_pkt_v || evict_v || fill_ready) begin
      misc_err_cnt++;
      $display("a valid or ready output was high right after reset");
    end
    send_req("cold_load", e_vcache_ld, 16'h0100, '0);
    send_req("cold_load", e_vcache_ld, 16'h0203, '0);
    send_req("cold_load", e_vcache_ld, 16'h1234, '0);
    send_req("store_then_load", e_vcache_st, 16'h0100, 32'hcafe_0001);
    send_req("store_then_load", e_vcache_ld, 16'h0100, '0);
    send_req("store_then_load", e_vcache_st, 16'h0203, 32'hcafe_0002);
    send_req("store_then_load", e_vcache_ld, 16'h0203, '0);
    send_req("conflict_evict", e_vcache_st, 16'h0010, 32'hbeef_0010); // same set as 0x0050.
    send_req("conflict_evict", e_vcache_st, 16'h0050, 32'hbeef_0050);
    send_req("conflict_evict", e_vcache_ld, 16'h0010, '0);
    send_req("conflict_evict", e_vcache_ld, 16'h0050, '0);
    for (int i = 0; i < num_rand_c; i++) begin
      if ($urandom_range(3) == 0) @(negedge clk);
      send_req("random", ($urandom_range(1) == 1) ? e_vcache_st : e_vcache_ld,
               16'h0400 + 16'($urandom_range(127)), $urandom);
    end
    while (resp_cnt != req_cnt) @(negedge clk);
    repeat (20) @(negedge clk); // a late extra response would show up here.
    check_count("drain_responses", req_cnt, resp_cnt);
    check_count("drain_requests", total_req_c, req_cnt);
    check_count("drain_queue", 0, exp_q.size());
    $display("errors: response %0d, dma %0d, other %0d; requests %0d, responses %0d",
             resp_err_cnt, dma_err_cnt, misc_err_cnt, req_cnt, resp_cnt);
    if (resp_err_cnt + dma_err_cnt + misc_err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vcache_core.sv */
module vcache_core
  import vcache_pkg::*;
#(
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    cmd_v_i,
  input  vcache_cmd_s             cmd_i,
  output logic                    cmd_ready_o,

  output logic                    data_v_o,
  output logic [data_width_c-1:0] data_o,
  input  logic                    data_ready_i,

  output logic                    dma_pkt_v_o,
  output vcache_dma_pkt_s         dma_pkt_o,
  input  logic                    dma_pkt_ready_i,

  input  logic                    dma_data_v_i,
  input  logic [data_width_c-1:0] dma_data_i,
  output logic                    dma_data_ready_o,

  output logic                    dma_data_v_o,
  output logic [data_width_c-1:0] dma_data_o,
  input  logic                    dma_data_ready_i
);

  localparam int offset_width_lp = $clog2(block_size_in_words_p);
  localparam int index_width_lp  = $clog2(sets_p);
  localparam int tag_width_lp    = net_addr_width_c - index_width_lp - offset_width_lp;
  localparam int depth_lp        = sets_p * block_size_in_words_p;
  localparam logic [offset_width_lp-1:0] last_word_lp =
    offset_width_lp'(block_size_in_words_p - 1);

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_evict_cmd,
    s_evict_data,
    s_fill_cmd,
    s_fill_data,
    s_respond
  } state_e;

  state_e                     state_r;
  state_e                     state_n;
  vcache_cmd_s                cmd_r;
  logic [tag_width_lp-1:0]    tag_mem_r [sets_p];
  logic [data_width_c-1:0]    data_mem_r [depth_lp];
  logic [sets_p-1:0]          valid_r;
  logic [sets_p-1:0]          dirty_r;
  logic [offset_width_lp-1:0] cnt_r;

  logic [tag_width_lp-1:0]    tag;
  logic [index_width_lp-1:0]  index;
  logic [offset_width_lp-1:0] offset;
  logic                       hit;
  logic                       access;
  logic                       access_done;
  logic                       evict_beat;
  logic                       fill_beat;
  logic                       last_beat;
  logic                       is_store;

  assign {tag, index, offset} = cmd_r.addr;

  assign hit         = valid_r[index] && (tag_mem_r[index] == tag);
  assign access      = ((state_r == s_lookup) && hit) || (state_r == s_respond);
  assign access_done = access && data_ready_i;
  assign is_store    = (cmd_r.op == e_vcache_st);

  assign cmd_ready_o = (state_r == s_idle);
  assign data_v_o    = access;
  assign data_o      = data_mem_r[{index, offset}]; // stores return this too, the join zeroes it.

  assign dma_pkt_v_o      = (state_r == s_evict_cmd) || (state_r == s_fill_cmd);
  assign dma_data_v_o     = (state_r == s_evict_data);
  assign dma_data_o       = data_mem_r[{index, cnt_r}];
  assign dma_data_ready_o = (state_r == s_fill_data);

  assign evict_beat = dma_data_v_o && dma_data_ready_i;
  assign fill_beat  = dma_data_v_i && dma_data_ready_o;
  assign last_beat  = (cnt_r == last_word_lp);

  // a write-back goes to the address of the tag still in the array.
  always_comb begin
    dma_pkt_o.write_not_read = (state_r == s_evict_cmd);
    if (state_r == s_evict_cmd) begin
      dma_pkt_o.addr = {tag_mem_r[index], index, {offset_width_lp{1'b0}}};
    end else begin
      dma_pkt_o.addr = {tag, index, {offset_width_lp{1'b0}}};
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle: begin
        if (cmd_v_i) state_n = s_lookup;
      end
      s_lookup: begin
        if (!hit) begin
          state_n = (valid_r[index] && dirty_r[index]) ? s_evict_cmd : s_fill_cmd;
        end else if (data_ready_i) begin
          state_n = s_idle;
        end
      end
      s_evict_cmd: begin
        if (dma_pkt_ready_i) state_n = s_evict_data;
      end
      s_evict_data: begin
        if (evict_beat && last_beat) state_n = s_fill_cmd;
      end
      s_fill_cmd: begin
        if (dma_pkt_ready_i) state_n = s_fill_data;
      end
      s_fill_data: begin
        if (fill_beat && last_beat) state_n = s_respond;
      end
      s_respond: begin
        if (data_ready_i) state_n = s_idle;
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= s_idle;
      valid_r <= '0;
      dirty_r <= '0;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (evict_beat || fill_beat) cnt_r <= cnt_r + 1'b1; // wraps to zero after the last word.
      if (fill_beat && last_beat) begin
        valid_r[index] <= 1'b1;
        dirty_r[index] <= 1'b0;
      end
      if (access_done && is_store) dirty_r[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i && cmd_ready_o) cmd_r <= cmd_i;
    if (fill_beat && last_beat) tag_mem_r[index] <= tag;
    if (fill_beat) begin
      data_mem_r[{index, cnt_r}] <= dma_data_i;
    end else if (access_done && is_store) begin
      data_mem_r[{index, offset}] <= cmd_r.data;
    end
  end

endmodule

/* vcache_fifo.sv */
module vcache_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     ready_i
);

  payload_t   mem_r [2];
  logic       wptr_r;
  logic       rptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];
  assign ready_o = (count_r != 2'd2) || ready_i; // a full FIFO still takes a word while it pops.
  assign enq     = v_i && ready_o;
  assign deq     = v_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (deq) rptr_r <= ~rptr_r;
      if (enq && !deq) count_r <= count_r + 2'd1;
      else if (deq && !enq) count_r <= count_r - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wptr_r] <= data_i;
  end

endmodule

/* vcache_link_in.sv */
module vcache_link_in
  import vcache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,

  input  logic             req_v_i,
  input  vcache_req_pkt_s  req_i,
  output logic             req_ready_o,

  output logic             cmd_v_o,
  output vcache_cmd_s      cmd_o,
  input  logic             cmd_ready_i,

  output logic             ret_v_o,
  output vcache_ret_info_s ret_o,
  input  logic             ret_ready_i
);

  logic            pkt_v;
  vcache_req_pkt_s pkt;
  logic            pkt_pop;

  vcache_fifo #(
    .payload_t (vcache_req_pkt_s)
  ) req_fifo_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (req_v_i),
    .data_i  (req_i),
    .ready_o (req_ready_o),
    .v_o     (pkt_v),
    .data_o  (pkt),
    .ready_i (pkt_pop)
  );

  // Each side only sees a valid packet when the other side can take it too,
  // so a command never goes out without its return information.
  assign pkt_pop = pkt_v && cmd_ready_i && ret_ready_i;
  assign cmd_v_o = pkt_v && ret_ready_i;
  assign ret_v_o = pkt_v && cmd_ready_i;

  always_comb begin
    cmd_o.op   = pkt.op;
    cmd_o.addr = pkt.addr;
    cmd_o.data = pkt.data;
  end

  always_comb begin
    ret_o.op      = pkt.op;
    ret_o.src_x   = pkt.src_x;
    ret_o.src_y   = pkt.src_y;
    ret_o.load_id = pkt.load_id;
  end

endmodule

/* vcache_pkg.sv */
package vcache_pkg;

  localparam int data_width_c     = 32;
  localparam int x_cord_width_c   = 4;
  localparam int y_cord_width_c   = 3;
  localparam int load_id_width_c  = 5;
  localparam int net_addr_width_c = 16; // word address, no byte offset.

  typedef enum logic {
    e_vcache_ld = 1'b0,
    e_vcache_st = 1'b1
  } vcache_op_e;

  // request packet as it arrives from the network.
  typedef struct packed {
    vcache_op_e                   op;
    logic [net_addr_width_c-1:0]  addr;
    logic [data_width_c-1:0]      data;
    logic [x_cord_width_c-1:0]    src_x;
    logic [y_cord_width_c-1:0]    src_y;
    logic [load_id_width_c-1:0]   load_id;
  } vcache_req_pkt_s;

  // everything the response needs except the data word.
  typedef struct packed {
    vcache_op_e                   op;
    logic [x_cord_width_c-1:0]    src_x;
    logic [y_cord_width_c-1:0]    src_y;
    logic [load_id_width_c-1:0]   load_id;
  } vcache_ret_info_s;

  typedef struct packed {
    vcache_op_e                   op;
    logic [net_addr_width_c-1:0]  addr;
    logic [data_width_c-1:0]      data;
  } vcache_cmd_s;

  typedef struct packed {
    vcache_op_e                   op;
    logic [x_cord_width_c-1:0]    dst_x;
    logic [y_cord_width_c-1:0]    dst_y;
    logic [load_id_width_c-1:0]   load_id;
    logic [data_width_c-1:0]      data;
  } vcache_resp_pkt_s;

  // the address is the first word of the block.
  typedef struct packed {
    logic                         write_not_read;
    logic [net_addr_width_c-1:0]  addr;
  } vcache_dma_pkt_s;

endpackage

/* vcache_resp_out.sv */
module vcache_resp_out
  import vcache_pkg::*;
(
  input  logic                    data_v_i,
  input  logic [data_width_c-1:0] data_i,
  output logic                    data_ready_o,

  input  logic                    ret_v_i,
  input  vcache_ret_info_s        ret_i,
  output logic                    ret_ready_o,

  output logic                    resp_v_o,
  output vcache_resp_pkt_s        resp_o,
  input  logic                    resp_ready_i
);

  logic is_store;

  assign is_store = (ret_i.op == e_vcache_st);

  // both halves leave together or not at all.
  assign resp_v_o     = data_v_i && ret_v_i;
  assign data_ready_o = resp_ready_i && ret_v_i;
  assign ret_ready_o  = resp_ready_i && data_v_i;

  always_comb begin
    resp_o.op      = ret_i.op;
    resp_o.dst_x   = ret_i.src_x;
    resp_o.dst_y   = ret_i.src_y;
    resp_o.load_id = ret_i.load_id;
    resp_o.data    = is_store ? '0 : data_i; // store acknowledge.
  end

endmodule

/* vcache_top.sv */
module vcache_top
  import vcache_pkg::*;
#(
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    req_v_i,
  input  vcache_req_pkt_s         req_i,
  output logic                    req_ready_o,

  output logic                    resp_v_o,
  output vcache_resp_pkt_s        resp_o,
  input  logic                    resp_ready_i,

  output logic                    dma_pkt_v_o,
  output vcache_dma_pkt_s         dma_pkt_o,
  input  logic                    dma_pkt_ready_i,

  input  logic                    dma_data_v_i,
  input  logic [data_width_c-1:0] dma_data_i,
  output logic                    dma_data_ready_o,

  output logic                    dma_data_v_o,
  output logic [data_width_c-1:0] dma_data_o,
  input  logic                    dma_data_ready_i
);

  logic                    cmd_v;
  vcache_cmd_s             cmd;
  logic                    cmd_ready;
  logic                    ret_v;
  vcache_ret_info_s        ret;
  logic                    ret_ready;
  logic                    ret_q_v;
  vcache_ret_info_s        ret_q;
  logic                    ret_q_ready;
  logic                    data_v;
  logic [data_width_c-1:0] data;
  logic                    data_ready;

  vcache_link_in link_in_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_v_i     (req_v_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .cmd_v_o     (cmd_v),
    .cmd_o       (cmd),
    .cmd_ready_i (cmd_ready),
    .ret_v_o     (ret_v),
    .ret_o       (ret),
    .ret_ready_i (ret_ready)
  );

  // return information waits here while the core works on the access.
  vcache_fifo #(
    .payload_t (vcache_ret_info_s)
  ) ret_fifo_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (ret_v),
    .data_i  (ret),
    .ready_o (ret_ready),
    .v_o     (ret_q_v),
    .data_o  (ret_q),
    .ready_i (ret_q_ready)
  );

  vcache_core #(
    .sets_p                (sets_p),
    .block_size_in_words_p (block_size_in_words_p)
  ) core_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cmd_v_i          (cmd_v),
    .cmd_i            (cmd),
    .cmd_ready_o      (cmd_ready),
    .data_v_o         (data_v),
    .data_o           (data),
    .data_ready_i     (data_ready),
    .dma_pkt_v_o      (dma_pkt_v_o),
    .dma_pkt_o        (dma_pkt_o),
    .dma_pkt_ready_i  (dma_pkt_ready_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_i       (dma_data_i),
    .dma_data_ready_o (dma_data_ready_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_o       (dma_data_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

  vcache_resp_out resp_out_inst (
    .data_v_i     (data_v),
    .data_i       (data),
    .data_ready_o (data_ready),
    .ret_v_i      (ret_q_v),
    .ret_i        (ret_q),
    .ret_ready_o  (ret_q_ready),
    .resp_v_o     (resp_v_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

endmodule

/* vlog.f */
vcache_pkg.sv
vcache_fifo.sv
vcache_link_in.sv
vcache_core.sv
vcache_resp_out.sv
vcache_top.sv
tb_dma_mem.sv
tb_vcache.sv
